/* hw/core_params.svh */
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

`define XLEN     64
`define ILEN     32
`define OP_SEL_W 2
`define ALU_OPW  4
`define RF_AW    5

// RV64I major opcodes.
`define OPC_OP     7'b0110011
`define OPC_OP_IMM 7'b0010011
`define OPC_LUI    7'b0110111
`define OPC_AUIPC  7'b0010111
`define OPC_JAL    7'b1101111
`define OPC_JALR   7'b1100111
`define OPC_BRANCH 7'b1100011
`define OPC_LOAD   7'b0000011
`define OPC_STORE  7'b0100011

`endif

/* hw/core_pkg.sv */
`default_nettype none

`include "core_params.svh"

package core_pkg;

   typedef logic [`XLEN-1:0]     xlen_t;
   typedef logic [`ILEN-1:0]     insn_t;
   typedef logic [`RF_AW-1:0]    reg_idx_t;
   typedef logic [`OP_SEL_W-1:0] op_sel_t;
   typedef logic [`ALU_OPW-1:0]  alu_op_t;
   typedef logic [3:0]           lsu_size_t;

   localparam op_sel_t OPS_RS1_RS2  = 2'd0;
   localparam op_sel_t OPS_RS1_IMM  = 2'd1;
   localparam op_sel_t OPS_PC_IMM   = 2'd2;
   localparam op_sel_t OPS_ZERO_IMM = 2'd3;

   // {funct7[5], funct3}
   localparam alu_op_t ALU_ADD  = 4'b0000;
   localparam alu_op_t ALU_SUB  = 4'b1000;
   localparam alu_op_t ALU_SLL  = 4'b0001;
   localparam alu_op_t ALU_SLT  = 4'b0010;
   localparam alu_op_t ALU_SLTU = 4'b0011;
   localparam alu_op_t ALU_XOR  = 4'b0100;
   localparam alu_op_t ALU_SRL  = 4'b0101;
   localparam alu_op_t ALU_SRA  = 4'b1101;
   localparam alu_op_t ALU_OR   = 4'b0110;
   localparam alu_op_t ALU_AND  = 4'b0111;

   localparam lsu_size_t LSU_B = 4'b0001;
   localparam lsu_size_t LSU_H = 4'b0010;
   localparam lsu_size_t LSU_W = 4'b0100;
   localparam lsu_size_t LSU_D = 4'b1000;

endpackage

`default_nettype wire

/* hw/idu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module idu
   import core_pkg::*;
(
   input  insn_t     insn,
   input  logic      insn_valid,
   input  xlen_t     pc,
   output logic      rf_we,
   output reg_idx_t  rd,
   output reg_idx_t  rs1_addr,
   output reg_idx_t  rs2_addr,
   output op_sel_t   op_sel,
   output alu_op_t   fu_sel,
   output logic      lsu_load,
   output logic      lsu_store,
   output logic      lsu_sigext,
   output lsu_size_t lsu_size,
   output logic      wb_sel,
   output logic      branch,
   output logic      jump,
   output logic [11:0] imm12,
   output logic [12:0] imm13,
   output logic [19:0] imm20,
   output logic [20:0] imm21,
   output logic      valid,
   output xlen_t     pc_out,
   output insn_t     insn_out
);

   logic [6:0] opcode;
   logic [2:0] funct3;

   assign opcode = insn[6:0];
   assign funct3 = insn[14:12];

   always_comb
   begin
      rf_we     = 1'b0;
      op_sel    = OPS_RS1_RS2;
      fu_sel    = ALU_ADD;
      lsu_load  = 1'b0;
      lsu_store = 1'b0;
      wb_sel    = 1'b0;
      branch    = 1'b0;
      jump      = 1'b0;
      case (opcode)
         `OPC_OP:
         begin
            rf_we  = 1'b1;
            fu_sel = {insn[30], funct3};
         end
         `OPC_OP_IMM:
         begin
            rf_we  = 1'b1;
            op_sel = OPS_RS1_IMM;
            fu_sel = {(funct3 == 3'b101) & insn[30], funct3}; // Bit 30 only marks SRAI.
         end
         `OPC_LUI:
         begin
            rf_we  = 1'b1;
            op_sel = OPS_ZERO_IMM;
         end
         `OPC_AUIPC:
         begin
            rf_we  = 1'b1;
            op_sel = OPS_PC_IMM;
         end
         `OPC_JAL, `OPC_JALR:
         begin
            rf_we  = 1'b1;
            jump   = 1'b1;
            wb_sel = 1'b1;                                 // Link value pc + 4.
            op_sel = (opcode == `OPC_JAL) ? OPS_PC_IMM : OPS_RS1_IMM;
         end
         `OPC_BRANCH:
            branch = 1'b1;
         `OPC_LOAD:
         begin
            rf_we    = 1'b1;
            lsu_load = 1'b1;
            op_sel   = OPS_RS1_IMM;
         end
         `OPC_STORE:
         begin
            lsu_store = 1'b1;
            op_sel    = OPS_RS1_IMM;
         end
         default: ;                                        // Bubble.
      endcase
   end

   always_comb
   begin
      lsu_size = '0;
      if (lsu_load | lsu_store)
         case (funct3[1:0])
            2'b00:   lsu_size = LSU_B;
            2'b01:   lsu_size = LSU_H;
            2'b10:   lsu_size = LSU_W;
            default: lsu_size = LSU_D;
         endcase
   end

   assign lsu_sigext = lsu_load & ~funct3[2];

   assign rd       = insn[11:7];
   assign rs1_addr = insn[19:15];
   assign rs2_addr = insn[24:20];

   // Raw immediates, extended in the execute stage.
   assign imm12 = lsu_store ? {insn[31:25], insn[11:7]} : insn[31:20];
   assign imm13 = {insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
   assign imm20 = insn[31:12];
   assign imm21 = {insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};

   assign valid    = insn_valid;
   assign pc_out   = pc;
   assign insn_out = insn;

endmodule

`default_nettype wire

/* hw/idu_exu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module idu_exu
   import core_pkg::*;
(
   input  logic        clk,
   input  logic        rst,
   input  logic        flush,
   input  logic        stall,
   input  logic        id_rf_we,
   input  reg_idx_t    id_rd,
   input  reg_idx_t    id_rs1_addr,
   input  reg_idx_t    id_rs2_addr,
   input  op_sel_t     id_op_sel,
   input  alu_op_t     id_fu_sel,
   input  logic        id_lsu_load,
   input  logic        id_lsu_store,
   input  logic        id_lsu_sigext,
   input  lsu_size_t   id_lsu_size,
   input  logic        id_wb_sel,
   input  logic        id_branch,
   input  logic        id_jump,
   input  logic [11:0] id_imm12,
   input  logic [12:0] id_imm13,
   input  logic [19:0] id_imm20,
   input  logic [20:0] id_imm21,
   input  logic        id_valid,
   input  xlen_t       id_pc,
   input  insn_t       id_insn,
   output logic        ex_rf_we,
   output reg_idx_t    ex_rd,
   output reg_idx_t    ex_rs1_addr,
   output reg_idx_t    ex_rs2_addr,
   output op_sel_t     ex_op_sel,
   output alu_op_t     ex_fu_sel,
   output logic        ex_lsu_load,
   output logic        ex_lsu_store,
   output logic        ex_lsu_sigext,
   output lsu_size_t   ex_lsu_size,
   output logic        ex_wb_sel,
   output logic        ex_branch,
   output logic        ex_jump,
   output logic [11:0] ex_imm12,
   output logic [12:0] ex_imm13,
   output logic [19:0] ex_imm20,
   output logic [20:0] ex_imm21,
   output logic        ex_valid,
   output xlen_t       ex_pc,
   output insn_t       ex_insn
);

   always_ff @(posedge clk)
   begin
      if (rst | flush)                                     // Flush wins over stall.
      begin
         ex_rf_we     <= 1'b0;
         ex_op_sel    <= '0;
         ex_fu_sel    <= '0;
         ex_lsu_load  <= 1'b0;
         ex_lsu_store <= 1'b0;
         ex_wb_sel    <= 1'b0;
         ex_branch    <= 1'b0;
         ex_jump      <= 1'b0;
         ex_valid     <= 1'b0;
      end
      else if (!stall)
      begin
         ex_rf_we     <= id_rf_we;
         ex_op_sel    <= id_op_sel;
         ex_fu_sel    <= id_fu_sel;
         ex_lsu_load  <= id_lsu_load;
         ex_lsu_store <= id_lsu_store;
         ex_wb_sel    <= id_wb_sel;
         ex_branch    <= id_branch;
         ex_jump      <= id_jump;
         ex_valid     <= id_valid;
      end
   end

   // Data fields only follow the stall.
   always_ff @(posedge clk)
   begin
      if (!stall)
      begin
         ex_rd         <= id_rd;
         ex_rs1_addr   <= id_rs1_addr;
         ex_rs2_addr   <= id_rs2_addr;
         ex_lsu_sigext <= id_lsu_sigext;
         ex_lsu_size   <= id_lsu_size;
         ex_imm12      <= id_imm12;
         ex_imm13      <= id_imm13;
         ex_imm20      <= id_imm20;
         ex_imm21      <= id_imm21;
         ex_pc         <= id_pc;
         ex_insn       <= id_insn;
      end
   end

endmodule

`default_nettype wire

/* hw/exu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module exu
   import core_pkg::*;
(
   input  logic        valid,
   input  logic        rf_we,
   input  reg_idx_t    rd,
   input  reg_idx_t    rs1_idx,
   input  reg_idx_t    rs2_idx,
   input  op_sel_t     op_sel,
   input  alu_op_t     fu_sel,
   input  logic        lsu_load,
   input  logic        lsu_store,
   input  logic        lsu_sigext,
   input  lsu_size_t   lsu_size,
   input  logic        wb_sel,
   input  logic        branch,
   input  logic        jump,
   input  logic [11:0] imm12,
   input  logic [12:0] imm13,
   input  logic [19:0] imm20,
   input  logic [20:0] imm21,
   input  xlen_t       pc,
   input  insn_t       insn,
   input  xlen_t       rs1_data,
   input  xlen_t       rs2_data,
   output reg_idx_t    rs1_addr,
   output reg_idx_t    rs2_addr,
   output logic        ex_valid,
   output logic        ex_rf_we,
   output reg_idx_t    ex_rd,
   output xlen_t       ex_result,
   output logic        ex_load,
   output logic        ex_store,
   output lsu_size_t   ex_lsu_size,
   output logic        ex_lsu_sigext,
   output xlen_t       ex_mem_addr,
   output xlen_t       ex_store_data,
   output logic        ex_branch_taken,
   output xlen_t       ex_branch_target
);

   xlen_t      imm_i, imm_u, imm_b, imm_j;
   xlen_t      op_a, op_b, alu_out, addr_sum;
   logic [5:0] shamt;
   logic       cond;
   logic       is_jal;

   assign imm_i = {{(`XLEN-12){imm12[11]}}, imm12};
   assign imm_u = {{(`XLEN-32){imm20[19]}}, imm20, 12'b0};
   assign imm_b = {{(`XLEN-13){imm13[12]}}, imm13};
   assign imm_j = {{(`XLEN-21){imm21[20]}}, imm21};

   always_comb
   begin
      op_a = rs1_data;
      op_b = rs2_data;
      case (op_sel)
         OPS_RS1_IMM:  op_b = imm_i;
         OPS_PC_IMM:
         begin
            op_a = pc;
            op_b = imm_u;
         end
         OPS_ZERO_IMM:
         begin
            op_a = '0;
            op_b = imm_u;
         end
         default: ;                                        // rs1 with rs2.
      endcase
   end

   assign shamt = op_b[5:0];

   always_comb
   begin
      case (fu_sel)
         ALU_SUB:  alu_out = op_a - op_b;
         ALU_SLL:  alu_out = op_a << shamt;
         ALU_SLT:  alu_out = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
         ALU_SLTU: alu_out = {{(`XLEN-1){1'b0}}, op_a < op_b};
         ALU_XOR:  alu_out = op_a ^ op_b;
         ALU_SRL:  alu_out = op_a >> shamt;
         ALU_SRA:  alu_out = $signed(op_a) >>> shamt;
         ALU_OR:   alu_out = op_a | op_b;
         ALU_AND:  alu_out = op_a & op_b;
         default:  alu_out = op_a + op_b;                  // ALU_ADD.
      endcase
   end

   always_comb
   begin
      case (insn[14:12])
         3'b000:  cond = rs1_data == rs2_data;
         3'b001:  cond = rs1_data != rs2_data;
         3'b100:  cond = $signed(rs1_data) < $signed(rs2_data);
         3'b101:  cond = $signed(rs1_data) >= $signed(rs2_data);
         3'b110:  cond = rs1_data < rs2_data;
         3'b111:  cond = rs1_data >= rs2_data;
         default: cond = 1'b0;
      endcase
   end

   assign addr_sum = rs1_data + imm_i;                    // Loads, stores and JALR.
   assign is_jal   = insn[6:0] == `OPC_JAL;

   assign rs1_addr = rs1_idx;
   assign rs2_addr = rs2_idx;

   assign ex_valid      = valid;
   assign ex_rf_we      = valid & rf_we;
   assign ex_rd         = rd;
   assign ex_result     = wb_sel ? pc + 64'd4 : alu_out;
   assign ex_load       = valid & lsu_load;
   assign ex_store      = valid & lsu_store;
   assign ex_lsu_size   = lsu_size;
   assign ex_lsu_sigext = lsu_sigext;
   assign ex_mem_addr   = addr_sum;
   assign ex_store_data = rs2_data;

   assign ex_branch_taken  = valid & (jump | (branch & cond));
   assign ex_branch_target = !jump ? pc + imm_b :
                             is_jal ? pc + imm_j : {addr_sum[`XLEN-1:1], 1'b0};

endmodule

`default_nettype wire

/* hw/dx_slice_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module dx_slice_top
   import core_pkg::*;
(
   input  logic      clk,
   input  logic      rst,
   input  insn_t     insn,
   input  logic      insn_valid,
   input  xlen_t     pc,
   input  logic      stall,
   input  logic      flush,
   input  xlen_t     rs1_data,
   input  xlen_t     rs2_data,
   output reg_idx_t  rs1_addr,
   output reg_idx_t  rs2_addr,
   output logic      ex_valid,
   output logic      ex_rf_we,
   output reg_idx_t  ex_rd,
   output xlen_t     ex_result,
   output logic      ex_load,
   output logic      ex_store,
   output lsu_size_t ex_lsu_size,
   output logic      ex_lsu_sigext,
   output xlen_t     ex_mem_addr,
   output xlen_t     ex_store_data,
   output logic      ex_branch_taken,
   output xlen_t     ex_branch_target
);

   // Decode stage.
   logic        id_rf_we, id_load, id_store, id_sigext, id_wb_sel, id_branch, id_jump, id_valid;
   reg_idx_t    id_rd, id_rs1, id_rs2;
   op_sel_t     id_op_sel;
   alu_op_t     id_fu_sel;
   lsu_size_t   id_size;
   logic [11:0] id_imm12;
   logic [12:0] id_imm13;
   logic [19:0] id_imm20;
   logic [20:0] id_imm21;
   xlen_t       id_pc;
   insn_t       id_insn;

   // Execute stage, registered.
   logic        xs_rf_we, xs_load, xs_store, xs_sigext, xs_wb_sel, xs_branch, xs_jump, xs_valid;
   reg_idx_t    xs_rd, xs_rs1, xs_rs2;
   op_sel_t     xs_op_sel;
   alu_op_t     xs_fu_sel;
   lsu_size_t   xs_size;
   logic [11:0] xs_imm12;
   logic [12:0] xs_imm13;
   logic [19:0] xs_imm20;
   logic [20:0] xs_imm21;
   xlen_t       xs_pc;
   insn_t       xs_insn;

   idu u_idu (
      .insn(insn), .insn_valid(insn_valid), .pc(pc),
      .rf_we(id_rf_we), .rd(id_rd), .rs1_addr(id_rs1), .rs2_addr(id_rs2),
      .op_sel(id_op_sel), .fu_sel(id_fu_sel),
      .lsu_load(id_load), .lsu_store(id_store), .lsu_sigext(id_sigext), .lsu_size(id_size),
      .wb_sel(id_wb_sel), .branch(id_branch), .jump(id_jump),
      .imm12(id_imm12), .imm13(id_imm13), .imm20(id_imm20), .imm21(id_imm21),
      .valid(id_valid), .pc_out(id_pc), .insn_out(id_insn)
   );

   idu_exu u_idu_exu (
      .clk(clk), .rst(rst), .flush(flush), .stall(stall),
      .id_rf_we(id_rf_we), .id_rd(id_rd), .id_rs1_addr(id_rs1), .id_rs2_addr(id_rs2),
      .id_op_sel(id_op_sel), .id_fu_sel(id_fu_sel),
      .id_lsu_load(id_load), .id_lsu_store(id_store),
      .id_lsu_sigext(id_sigext), .id_lsu_size(id_size),
      .id_wb_sel(id_wb_sel), .id_branch(id_branch), .id_jump(id_jump),
      .id_imm12(id_imm12), .id_imm13(id_imm13), .id_imm20(id_imm20), .id_imm21(id_imm21),
      .id_valid(id_valid), .id_pc(id_pc), .id_insn(id_insn),
      .ex_rf_we(xs_rf_we), .ex_rd(xs_rd), .ex_rs1_addr(xs_rs1), .ex_rs2_addr(xs_rs2),
      .ex_op_sel(xs_op_sel), .ex_fu_sel(xs_fu_sel),
      .ex_lsu_load(xs_load), .ex_lsu_store(xs_store),
      .ex_lsu_sigext(xs_sigext), .ex_lsu_size(xs_size),
      .ex_wb_sel(xs_wb_sel), .ex_branch(xs_branch), .ex_jump(xs_jump),
      .ex_imm12(xs_imm12), .ex_imm13(xs_imm13), .ex_imm20(xs_imm20), .ex_imm21(xs_imm21),
      .ex_valid(xs_valid), .ex_pc(xs_pc), .ex_insn(xs_insn)
   );

   exu u_exu (
      .valid(xs_valid), .rf_we(xs_rf_we), .rd(xs_rd), .rs1_idx(xs_rs1), .rs2_idx(xs_rs2),
      .op_sel(xs_op_sel), .fu_sel(xs_fu_sel),
      .lsu_load(xs_load), .lsu_store(xs_store), .lsu_sigext(xs_sigext), .lsu_size(xs_size),
      .wb_sel(xs_wb_sel), .branch(xs_branch), .jump(xs_jump),
      .imm12(xs_imm12), .imm13(xs_imm13), .imm20(xs_imm20), .imm21(xs_imm21),
      .pc(xs_pc), .insn(xs_insn), .rs1_data(rs1_data), .rs2_data(rs2_data),
      .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
      .ex_valid(ex_valid), .ex_rf_we(ex_rf_we), .ex_rd(ex_rd), .ex_result(ex_result),
      .ex_load(ex_load), .ex_store(ex_store),
      .ex_lsu_size(ex_lsu_size), .ex_lsu_sigext(ex_lsu_sigext),
      .ex_mem_addr(ex_mem_addr), .ex_store_data(ex_store_data),
      .ex_branch_taken(ex_branch_taken), .ex_branch_target(ex_branch_target)
   );

endmodule

`default_nettype wire

/* verification/dx_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module dx_checker
   import core_pkg::*;
(
   input logic      clk,
   input logic      rst,
   input logic      stall,
   input logic      flush,
   input logic      ex_valid,
   input logic      ex_rf_we,
   input reg_idx_t  ex_rd,
   input xlen_t     ex_result,
   input logic      ex_load,
   input logic      ex_store,
   input lsu_size_t ex_lsu_size,
   input logic      ex_lsu_sigext,
   input xlen_t     ex_mem_addr,
   input xlen_t     ex_store_data,
   input logic      ex_branch_taken,
   input xlen_t     ex_branch_target
);

   logic [270:0] ex_all;

   assign ex_all = {ex_valid, ex_rf_we, ex_rd, ex_result, ex_load, ex_store, ex_lsu_size,
                    ex_lsu_sigext, ex_mem_addr, ex_store_data, ex_branch_taken,
                    ex_branch_target};

   a_reset_bubble: assert property (@(posedge clk) rst |=> !ex_valid)
      else $error("ex_valid high after reset");

   a_load_store: assert property (@(posedge clk) disable iff (rst) !(ex_load && ex_store))
      else $error("ex_load and ex_store both high");

   a_idle_quiet: assert property (@(posedge clk) disable iff (rst)
      !ex_valid |-> !(ex_rf_we || ex_load || ex_store || ex_branch_taken))
      else $error("control output high without ex_valid");

   // A held register leaves every output unchanged.
   a_stall_hold: assert property (@(posedge clk) disable iff (rst)
      stall && !flush |=> $stable(ex_all))
      else $error("ex_ outputs changed under stall");

endmodule

bind dx_slice_top dx_checker u_dx_checker (
   .clk(clk), .rst(rst), .stall(stall), .flush(flush),
   .ex_valid(ex_valid), .ex_rf_we(ex_rf_we), .ex_rd(ex_rd), .ex_result(ex_result),
   .ex_load(ex_load), .ex_store(ex_store), .ex_lsu_size(ex_lsu_size),
   .ex_lsu_sigext(ex_lsu_sigext), .ex_mem_addr(ex_mem_addr), .ex_store_data(ex_store_data),
   .ex_branch_taken(ex_branch_taken), .ex_branch_target(ex_branch_target)
);

`default_nettype wire

/* verification/dx_scoreboard.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module dx_scoreboard
   import core_pkg::*;
(
   input  logic      clk,
   input  logic      rst,
   input  insn_t     insn,
   input  logic      insn_valid,
   input  xlen_t     pc,
   input  logic      stall,
   input  logic      flush,
   input  xlen_t     rs1_data,
   input  xlen_t     rs2_data,
   input  reg_idx_t  rs1_addr,
   input  reg_idx_t  rs2_addr,
   input  logic      ex_valid,
   input  logic      ex_rf_we,
   input  reg_idx_t  ex_rd,
   input  xlen_t     ex_result,
   input  logic      ex_load,
   input  logic      ex_store,
   input  lsu_size_t ex_lsu_size,
   input  logic      ex_lsu_sigext,
   input  xlen_t     ex_mem_addr,
   input  xlen_t     ex_store_data,
   input  logic      ex_branch_taken,
   input  xlen_t     ex_branch_target,
   input  int        test_num,
   input  logic      test_done,
   input  logic      all_done,
   output int        fail_total
);

   typedef struct packed {
      logic      valid;
      logic      rf_we;
      reg_idx_t  rd;
      xlen_t     result;
      logic      load;
      logic      store;
      lsu_size_t size;
      logic      sigext;
      xlen_t     mem_addr;
      xlen_t     store_data;
      logic      taken;
      logic      has_target;
      xlen_t     target;
   } exp_t;

   insn_t c_insn;
   xlen_t c_pc;
   logic  c_valid;
   int    err_total  = 0;
   int    err_mark   = 0;
   int    tests_pass = 0;
   int    tests_fail = 0;
   exp_t  e;

   assign fail_total = err_total;

   function automatic string test_name(input int n);
      case (n)
         1:       return "reset";
         2:       return "alu";
         3:       return "upper_jump";
         4:       return "branch";
         5:       return "load_store";
         6:       return "stall_flush";
         default: return "idle";
      endcase
   endfunction

   function automatic xlen_t alu(input logic [2:0] f3, input logic alt,
                                 input xlen_t x, input xlen_t y);
      case (f3)
         3'd0:
            if (alt)
               return x - y;
            else
               return x + y;
         3'd1:    return x << y[5:0];
         3'd2:    return ($signed(x) < $signed(y)) ? 64'd1 : 64'd0;
         3'd3:    return (x < y) ? 64'd1 : 64'd0;
         3'd4:    return x ^ y;
         3'd5:
            if (alt)
               return $signed(x) >>> y[5:0];
            else
               return x >> y[5:0];
         3'd6:    return x | y;
         default: return x & y;
      endcase
   endfunction

   function automatic logic branch_cond(input logic [2:0] f3, input xlen_t x, input xlen_t y);
      case (f3)
         3'd0:    return x == y;
         3'd1:    return x != y;
         3'd4:    return $signed(x) < $signed(y);
         3'd5:    return $signed(x) >= $signed(y);
         3'd6:    return x < y;
         3'd7:    return x >= y;
         default: return 1'b0;
      endcase
   endfunction

   // Expected ex_ outputs from the RV64I rules.
   function automatic exp_t expected_outputs(input insn_t i, input xlen_t p, input logic v,
                                             input xlen_t a, input xlen_t b);
      exp_t       r;
      logic [2:0] f3;
      xlen_t      imm_i, imm_s, imm_b, imm_u, imm_j;
      r     = '0;
      f3    = i[14:12];
      imm_i = {{52{i[31]}}, i[31:20]};
      imm_s = {{52{i[31]}}, i[31:25], i[11:7]};
      imm_b = {{52{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
      imm_u = {{32{i[31]}}, i[31:12], 12'h000};
      imm_j = {{44{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
      r.valid = v;
      r.rd    = i[11:7];
      case (i[6:0])
         `OPC_OP:
         begin
            r.rf_we  = 1'b1;
            r.result = alu(f3, i[30], a, b);
         end
         `OPC_OP_IMM:
         begin
            r.rf_we  = 1'b1;
            r.result = alu(f3, (f3 == 3'b101) & i[30], a, imm_i);
         end
         `OPC_LUI:
         begin
            r.rf_we  = 1'b1;
            r.result = imm_u;
         end
         `OPC_AUIPC:
         begin
            r.rf_we  = 1'b1;
            r.result = p + imm_u;
         end
         `OPC_JAL, `OPC_JALR:
         begin
            r.rf_we      = 1'b1;
            r.result     = p + 64'd4;
            r.taken      = 1'b1;
            r.has_target = 1'b1;
            if (i[6:0] == `OPC_JAL)
               r.target = p + imm_j;
            else
               r.target = (a + imm_i) & ~64'd1;
         end
         `OPC_BRANCH:
         begin
            r.taken      = branch_cond(f3, a, b);
            r.has_target = 1'b1;
            r.target     = p + imm_b;
         end
         `OPC_LOAD:
         begin
            r.rf_we    = 1'b1;
            r.load     = 1'b1;
            r.mem_addr = a + imm_i;
            r.result   = a + imm_i;                      // ALU adds the address.
            r.size     = 4'b0001 << f3[1:0];
            r.sigext   = ~f3[2];
         end
         `OPC_STORE:
         begin
            r.store      = 1'b1;
            r.mem_addr   = a + imm_s;
            r.store_data = b;
            r.size       = 4'b0001 << f3[1:0];
         end
         default: ;                                      // Bubble with no effect.
      endcase
      r.rf_we = r.rf_we & v;
      r.load  = r.load & v;
      r.store = r.store & v;
      r.taken = r.taken & v;
      return r;
   endfunction

   task automatic check(input string field, input xlen_t exp_v, input xlen_t act_v);
      if (exp_v !== act_v)
      begin
         $display("[ERROR] %s %s: expected %h, actual %h", test_name(test_num), field,
                  exp_v, act_v);
         err_total = err_total + 1;
      end
   endtask

   // Expected entry follows the pipeline register.
   always @(posedge clk)
   begin
      if (rst)
      begin
         c_valid <= 1'b0;
      end
      else if (flush)
         c_valid <= 1'b0;
      else if (!stall)
      begin
         c_insn  <= insn;
         c_pc    <= pc;
         c_valid <= insn_valid;
      end
      if (test_done)
      begin
         if (err_total == err_mark)
         begin
            tests_pass <= tests_pass + 1;
            $display("Test %0d %s: passed", test_num, test_name(test_num));
         end
         else
         begin
            tests_fail <= tests_fail + 1;
            $display("Test %0d %s: failed with %0d errors", test_num, test_name(test_num),
                     err_total - err_mark);
         end
         err_mark <= err_total;
      end
      if (all_done)
         $display("Tests passed: %0d, tests failed: %0d", tests_pass, tests_fail);
   end

   // Outputs are settled mid-cycle.
   always @(negedge clk)
   begin
      if (!rst)
      begin
         e = expected_outputs(c_insn, c_pc, c_valid, rs1_data, rs2_data);
         check("ex_valid", 64'(e.valid), 64'(ex_valid));
         check("ex_rf_we", 64'(e.rf_we), 64'(ex_rf_we));
         check("ex_load", 64'(e.load), 64'(ex_load));
         check("ex_store", 64'(e.store), 64'(ex_store));
         check("ex_branch_taken", 64'(e.taken), 64'(ex_branch_taken));
         if (e.valid)
         begin
            check("rs1_addr", 64'(c_insn[19:15]), 64'(rs1_addr));
            check("rs2_addr", 64'(c_insn[24:20]), 64'(rs2_addr));
            check("ex_lsu_size", 64'(e.size), 64'(ex_lsu_size));
            check("ex_lsu_sigext", 64'(e.sigext), 64'(ex_lsu_sigext));
            if (e.rf_we)
            begin
               check("ex_rd", 64'(e.rd), 64'(ex_rd));
               check("ex_result", e.result, ex_result);
            end
            if (e.load || e.store)
               check("ex_mem_addr", e.mem_addr, ex_mem_addr);
            if (e.store)
               check("ex_store_data", e.store_data, ex_store_data);
            if (e.has_target)
               check("ex_branch_target", e.target, ex_branch_target);
         end
      end
   end

endmodule

`default_nettype wire

/* verification/tb_dx_slice.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module tb_dx_slice
   import core_pkg::*;
();

   localparam int SEED         = 89;
   localparam int RESET_CYCLES = 16;
   localparam int N_ALU        = 60;
   localparam int STIM_CYCLES  = 200;
   localparam int TIMEOUT      = 4 * STIM_CYCLES + RESET_CYCLES;

   logic      clk, rst, insn_valid, stall, flush;
   insn_t     insn;
   xlen_t     pc, rs1_data, rs2_data;
   reg_idx_t  rs1_addr, rs2_addr, ex_rd;
   logic      ex_valid, ex_rf_we, ex_load, ex_store, ex_lsu_sigext, ex_branch_taken;
   lsu_size_t ex_lsu_size;
   xlen_t     ex_result, ex_mem_addr, ex_store_data, ex_branch_target;
   int        test_num, fail_total, cycles;
   logic      test_done, all_done;

   // Branch operand pairs: equal, signed and unsigned orders that disagree, plain order.
   reg_idx_t   pair_a [4] = '{5'd3, 5'd4, 5'd5, 5'd2};
   reg_idx_t   pair_b [4] = '{5'd3, 5'd5, 5'd4, 5'd6};
   logic [2:0] br_f3  [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};

   dx_slice_top UUT (.*);

   dx_scoreboard u_scoreboard (.*);

   // Odd registers hold negative values.
   function automatic xlen_t rf_value(input reg_idx_t r);
      xlen_t v;
      v     = {8{3'b010, r}};
      v[63] = r[0];
      return (r == 5'd0) ? '0 : v;
   endfunction

   assign rs1_data = rf_value(rs1_addr);
   assign rs2_data = rf_value(rs2_addr);

   function automatic insn_t enc_r(input logic alt, input reg_idx_t rs2, input reg_idx_t rs1,
                                   input logic [2:0] f3, input reg_idx_t rd);
      return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, `OPC_OP};
   endfunction

   function automatic insn_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                   input logic [2:0] f3, input reg_idx_t rd,
                                   input logic [6:0] opc);
      return {imm, rs1, f3, rd, opc};
   endfunction

   function automatic insn_t enc_s(input logic [11:0] imm, input reg_idx_t rs2,
                                   input reg_idx_t rs1, input logic [2:0] f3);
      return {imm[11:5], rs2, rs1, f3, imm[4:0], `OPC_STORE};
   endfunction

   function automatic insn_t enc_b(input logic [12:0] imm, input reg_idx_t rs2,
                                   input reg_idx_t rs1, input logic [2:0] f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `OPC_BRANCH};
   endfunction

   function automatic insn_t enc_u(input logic [19:0] imm, input reg_idx_t rd,
                                   input logic [6:0] opc);
      return {imm, rd, opc};
   endfunction

   function automatic insn_t enc_j(input logic [20:0] imm, input reg_idx_t rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `OPC_JAL};
   endfunction

   function automatic insn_t rand_alu();
      logic [31:0] r;
      logic [2:0]  f3;
      logic [11:0] imm;
      r   = $urandom;
      f3  = r[2:0];
      imm = r[31:20];
      if (r[4])
         return enc_r(r[3] & (f3 == 3'b000 || f3 == 3'b101), r[9:5], r[14:10], f3, r[19:15]);
      if (f3 == 3'b001)
         imm = {6'b0, r[25:20]};                         // SLLI.
      if (f3 == 3'b101)
         imm = {1'b0, r[3], 4'b0, r[25:20]};             // SRLI or SRAI.
      return enc_i(imm, r[14:10], f3, r[19:15], `OPC_OP_IMM);
   endfunction

   function automatic xlen_t new_pc();
      xlen_t v;
      v      = {$urandom, $urandom};
      v[1:0] = 2'b00;
      return v;
   endfunction

   task automatic drive(input insn_t i, input xlen_t p, input logic st, input logic fl);
      @(posedge clk);
      #2;
      insn       = i;
      pc         = p;
      insn_valid = 1'b1;
      stall      = st;
      flush      = fl;
   endtask

   task automatic end_test();
      @(posedge clk);
      #2;
      insn_valid = 1'b0;
      stall      = 1'b0;
      flush      = 1'b0;
      @(posedge clk);
      #2;
      test_done = 1'b1;
      @(posedge clk);
      #2;
      test_done = 1'b0;
      test_num  = test_num + 1;
   endtask

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   initial
   begin
      cycles = 0;
   end

   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT)
      begin
         $display("Timeout: the tests did not finish within %0d cycles.", TIMEOUT);
         $display("CHECKS FAILED");
         $finish;
      end
   end

   initial
   begin
      logic [31:0] r;
      insn_t       ins;
      xlen_t       p;
      r          = $urandom(SEED);
      rst        = 1'b1;
      insn       = '0;
      insn_valid = 1'b0;
      pc         = '0;
      stall      = 1'b0;
      flush      = 1'b0;
      test_done  = 1'b0;
      all_done   = 1'b0;
      test_num   = 1;
      repeat (RESET_CYCLES) @(posedge clk);
      #2;
      rst = 1'b0;
      end_test();                                        // Reset values only.
      repeat (N_ALU) drive(rand_alu(), new_pc(), 1'b0, 1'b0);
      end_test();
      repeat (4)
      begin
         r = $urandom;
         drive(enc_u(r[31:12], r[11:7], `OPC_LUI), new_pc(), 1'b0, 1'b0);
         drive(enc_u(r[19:0], r[24:20], `OPC_AUIPC), new_pc(), 1'b0, 1'b0);
         drive(enc_j({r[31:12], 1'b0}, r[6:2]), new_pc(), 1'b0, 1'b0);
         drive(enc_i(r[11:0], r[16:12], 3'b000, r[21:17], `OPC_JALR), new_pc(), 1'b0, 1'b0);
      end
      end_test();
      foreach (br_f3[f])
         foreach (pair_a[k])
         begin
            r = $urandom;
            drive(enc_b({r[12:1], 1'b0}, pair_b[k], pair_a[k], br_f3[f]), new_pc(), 1'b0, 1'b0);
         end
      end_test();
      for (int k = 0; k < 7; k++)
      begin
         r = $urandom;
         drive(enc_i(r[11:0], r[16:12], 3'(k), r[21:17], `OPC_LOAD), new_pc(), 1'b0, 1'b0);
      end
      for (int k = 0; k < 4; k++)
      begin
         r = $urandom;
         drive(enc_s(r[11:0], r[26:22], r[16:12], 3'(k)), new_pc(), 1'b0, 1'b0);
      end
      end_test();
      repeat (20)
      begin
         ins = rand_alu();
         p   = new_pc();
         do
         begin
            r = $urandom;
            drive(ins, p, r[0], 1'b0);                   // Held until taken.
         end
         while (r[0]);
      end
      drive(rand_alu(), new_pc(), 1'b1, 1'b1);
      drive(rand_alu(), new_pc(), 1'b0, 1'b1);
      drive(enc_i(12'h0, 5'd1, 3'b000, 5'd2, 7'b0001111), new_pc(), 1'b0, 1'b0);
      end_test();
      all_done = 1'b1;
      @(posedge clk);
      #1;
      if (fail_total == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

/* tb.f */
+incdir+hw
hw/core_pkg.sv
hw/idu.sv
hw/idu_exu.sv
hw/exu.sv
hw/dx_slice_top.sv
verification/dx_checker.sv
verification/dx_scoreboard.sv
verification/tb_dx_slice.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_dx_slice
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "CHECKS FAILED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
